// ==== compile.f ====
+incdir+verilog
+incdir+tests
verilog/eval_pkg.sv
verilog/eval_control.sv
verilog/latency_timer.sv
verilog/material_sum.sv
verilog/phase_count.sv
verilog/taper_blend.sv
verilog/evaluate.sv
tests/tb_evaluate.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f compile.f --top-module tb_evaluate -Mdir obj_dir
	./obj_dir/Vtb_evaluate

clean:
	rm -rf obj_dir

// ==== tests/eval_model.svh ====
//**************************************************************************
// Evaluator reference model: xorshift source, board builders, expected score
//**************************************************************************
`ifndef EVAL_MODEL_SVH
`define EVAL_MODEL_SVH

logic [31:0] rng_state = 32'h5537;

function automatic logic [31:0] xorshift();
   logic [31:0] x;
   x = rng_state;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   rng_state = x;
   return x;
endfunction

function automatic board_t uniform_board(input logic [3:0] code);
   board_t b;
   for (int i = 0; i < 64; i++)
      b[i].raw = code;
   return b;
endfunction

function automatic board_t single_board(input int sq, input logic [3:0] code);
   board_t b;
   b = uniform_board(4'h0);
   b[sq].raw = code;
   return b;
endfunction

// Legal codes only, about half the squares empty unless dense
function automatic board_t random_board(input logic dense);
   board_t      b;
   logic [31:0] r;
   for (int i = 0; i < 64; i++)
   begin
      r = xorshift();
      if (dense)
         b[i].raw = {r[8], 3'(2 + r[7:0] % 5)};     // Knight to king
      else if (r[7:0] % 24 >= 12)
         b[i].raw = 4'h0;
      else
         b[i].raw = {r[8], 3'(1 + r[7:0] % 6)};     // Pawn to king
   end
   return b;
endfunction

function automatic int piece_value(input logic [2:0] kind, input logic endgame);
   case (kind)
      3'd1:    return endgame ? 94 : 82;            // Pawn
      3'd2:    return endgame ? 281 : 337;          // Knight
      3'd3:    return endgame ? 297 : 365;          // Bishop
      3'd4:    return endgame ? 512 : 477;          // Rook
      3'd5:    return endgame ? 936 : 1025;         // Queen
      default: return 0;                            // King, empty
   endcase
endfunction

// White positive, phase clamped to 62, divide truncates toward zero
function automatic eval_t eval_ref(input board_t b);
   longint mg;
   longint eg;
   longint blend;
   int     phase;
   int     sign;
   mg    = 0;
   eg    = 0;
   phase = 0;
   for (int i = 0; i < 64; i++)
   begin
      sign = b[i].fields.black ? -1 : 1;
      mg   = mg + longint'(sign * piece_value(b[i].fields.kind, 1'b0));
      eg   = eg + longint'(sign * piece_value(b[i].fields.kind, 1'b1));
      if (b[i].raw != 4'h0 && b[i].fields.kind != 3'd1)
         phase++;
   end
   if (phase > 62)
      phase = 62;
   blend = (mg * longint'(phase) + eg * longint'(62 - phase)) * 16912;
   return eval_t'(blend / 1048576);
endfunction

`endif

// ==== tests/tb_evaluate.sv ====
//**************************************************************************
// Testbench for the evaluator score stage, random and directed boards
//**************************************************************************
`default_nettype none

module tb_evaluate
   import eval_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_BOARDS      = 120;
   localparam int WATCHDOG_CYCLES = NUM_BOARDS * 60 + 200;

   logic   clk;
   logic   reset;
   logic   board_valid;
   logic   attack_done;
   board_t board_in;
   logic   clear_eval;
   eval_t  eval;
   logic   eval_valid;

   eval_t  expected_q[$];                           // One entry per launched board
   int     boards_run      = 0;
   int     results_checked = 0;

   `include "eval_model.svh"

   evaluate uut
   (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .attack_done (attack_done),
      .board_in    (board_in),
      .clear_eval  (clear_eval),
      .eval        (eval),
      .eval_valid  (eval_valid)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;                       // 20 ns period
   end

   task automatic check_eval(input string name, input eval_t expected, input eval_t actual);
      if (actual !== expected)
      begin
         $display("MISMATCH %s expected %h actual %h", name, expected, actual);
         $display("ERRORS FOUND");
         $fatal(1, "score check failed");
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         $display("MISMATCH %s expected %h actual %h", name, expected, actual);
         $display("ERRORS FOUND");
         $fatal(1, "flag check failed");
      end
   endtask

   // Compare process, one score per rising eval_valid
   initial
   begin
      forever
      begin
         @(posedge eval_valid);
         @(negedge clk);                            // Sample away from the edge
         if (expected_q.size() == 0)
         begin
            $display("eval_valid rose with no board in flight");
            $display("ERRORS FOUND");
            $fatal(1, "unexpected result");
         end
         else
         begin
            check_eval("eval", expected_q.pop_front(), eval);
            @(negedge clk);                         // Held until clear_eval is seen
            check_flag("eval_valid", 1'b1, eval_valid);
            results_checked++;
         end
      end
   end

   task automatic run_board(input board_t b, input int attack_delay, input int hold_cycles);
      eval_t expected;
      expected = eval_ref(b);
      @(negedge clk);
      board_valid = 1'b0;                           // Seen low in idle first
      @(negedge clk);
      board_in    = b;
      board_valid = 1'b1;
      expected_q.push_back(expected);
      boards_run++;
      @(negedge clk);
      board_valid = 1'b0;
      repeat (attack_delay)
      begin
         @(negedge clk);
         check_flag("eval_valid", 1'b0, eval_valid);  // Gated by attack_done
      end
      attack_done = 1'b1;
      while (!eval_valid)
         @(negedge clk);
      attack_done = 1'b0;
      repeat (hold_cycles)
      begin
         @(negedge clk);
         board_in    = random_board(1'b0);          // Ignored while held
         board_valid = 1'b1;
         check_eval("eval", expected, eval);
         check_flag("eval_valid", 1'b1, eval_valid);
      end
      @(negedge clk);
      clear_eval = 1'b1;                            // board_valid stays as is into idle
      @(negedge clk);
      clear_eval = 1'b0;
      check_flag("eval_valid", 1'b0, eval_valid);
   endtask

   initial
   begin
      board_t b;
      int     delay;
      reset       = 1'b1;
      board_valid = 1'b0;
      attack_done = 1'b0;
      board_in    = '0;
      clear_eval  = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      check_flag("eval_valid", 1'b0, eval_valid);

      run_board(uniform_board(4'h0), 0, 0);          // Empty board

      // Lone piece of each kind and color, codes 7 and 8 unused
      for (int code = 1; code < 15; code++)
         if (code != 7 && code != 8)
            run_board(single_board(xorshift() % 64, 4'(code)), 0, 0);

      for (int i = 0; i < 100; i++)
      begin
         if (i == 0)
            b = uniform_board(4'h5);                // All white queens
         else if (i == 1)
            b = uniform_board(4'hd);                // All black queens
         else
            b = random_board(i % 10 == 2);
         run_board(b, xorshift() % 3, 0);
      end

      for (int i = 0; i < 5; i++)
      begin
         delay = 15 + xorshift() % 16;              // Outlasts term and blend latency
         run_board(random_board(1'b0), delay, 0);
      end

      run_board(random_board(1'b0), 0, 12);          // Held result
      run_board(random_board(1'b1), 0, 0);           // New edge after the clear

      repeat (4) @(negedge clk);
      if (results_checked != boards_run || expected_q.size() != 0)
      begin
         $display("%0d boards sent but %0d results checked", boards_run, results_checked);
         $display("ERRORS FOUND");
         $fatal(1, "result count wrong");
      end
      else
      begin
         $display("NO ERRORS");
         $finish;
      end
   end

   // Watchdog
   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout, eval_valid never arrived");
      $display("ERRORS FOUND");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

// ==== verilog/evaluate.sv ====
//**************************************************************************
// Evaluator score stage top, material and phase terms blended by phase
//**************************************************************************
`default_nettype none

module evaluate
   import eval_pkg::*;
(
   input  wire         clk,
   input  wire         reset,
   input  wire         board_valid,
   input  wire         attack_done,
   input  wire board_t board_in,
   input  wire         clear_eval,
   output eval_t       eval,
   output logic        eval_valid
);

   board_t board;                                   // Held board
   logic   term_start, timer_start, timer_done;
   sum_t   material_mg, material_eg;
   logic   material_done;
   phase_t phase;
   logic   phase_done;

   eval_control u_control
   (
      .clk           (clk),
      .reset         (reset),
      .board_valid   (board_valid),
      .attack_done   (attack_done),
      .board_in      (board_in),
      .material_done (material_done),
      .phase_done    (phase_done),
      .timer_done    (timer_done),
      .clear_eval    (clear_eval),
      .board         (board),
      .term_start    (term_start),
      .timer_start   (timer_start),
      .eval_valid    (eval_valid)
   );

   latency_timer u_timer
   (
      .clk         (clk),
      .reset       (reset),
      .timer_start (timer_start),
      .timer_done  (timer_done)
   );

   material_sum u_material
   (
      .clk           (clk),
      .reset         (reset),
      .term_start    (term_start),
      .board         (board),
      .material_mg   (material_mg),
      .material_eg   (material_eg),
      .material_done (material_done)
   );

   phase_count u_phase
   (
      .clk        (clk),
      .reset      (reset),
      .term_start (term_start),
      .board      (board),
      .phase      (phase),
      .phase_done (phase_done)
   );

   // Free running, valid once the timer expires
   taper_blend u_blend
   (
      .clk         (clk),
      .material_mg (material_mg),
      .material_eg (material_eg),
      .phase       (phase),
      .eval        (eval)
   );

endmodule

`default_nettype wire

// ==== verilog/taper_blend.sv ====
//**************************************************************************
// Tapered blend pipeline, mg and eg totals weighted by phase over 62
//**************************************************************************
`include "eval_defs.svh"
`default_nettype none

module taper_blend
   import eval_pkg::*;
(
   input  wire       clk,
   input  wire sum_t material_mg,
   input  wire sum_t material_eg,
   input  wire phase_t phase,
   output eval_t     eval
);

   phase_t eg_weight;                               // 62 - phase
   calc_t  prod_mg, prod_eg;                        // Stage 1
   calc_t  blend_sum;                               // Stage 2
   calc_t  scaled;                                  // Stage 3
   calc_t  rounded;

   assign eg_weight = phase_t'(`EVAL_PHASE_MAX) - phase;

   // Bias negatives so the shift truncates toward zero like a divide
   assign rounded = scaled + (scaled[`EVAL_CALC_WIDTH-1] ?
                              calc_t'((1 << `EVAL_RECIP_SHIFT) - 1) : '0);

   always_ff @(posedge clk)
   begin
      prod_mg   <= calc_t'(material_mg) * calc_t'(phase);      // Phase zero-extended
      prod_eg   <= calc_t'(material_eg) * calc_t'(eg_weight);
      blend_sum <= prod_mg + prod_eg;
      scaled    <= blend_sum * calc_t'(`EVAL_RECIP);           // Stands in for / 62
      eval      <= eval_t'(rounded >>> `EVAL_RECIP_SHIFT);
   end

endmodule

`default_nettype wire

// ==== verilog/phase_count.sv ====
//**************************************************************************
// Game phase, count of non-pawn pieces clamped to 62
//**************************************************************************
`include "eval_defs.svh"
`default_nettype none

module phase_count
   import eval_pkg::*;
(
   input  wire         clk,
   input  wire         reset,
   input  wire         term_start,
   input  wire board_t board,
   output phase_t      phase,
   output logic        phase_done
);

   logic [`EVAL_SQUARES-1:0] occupied;              // Stage one, non-pawn squares
   logic                     occ_valid;
   count_t                   occ_count;

   always_comb
   begin
      occ_count = '0;
      for (int i = 0; i < `EVAL_SQUARES; i++)
         occ_count = occ_count + count_t'(occupied[i]);
   end

   always_ff @(posedge clk)
   begin
      if (term_start)
         for (int i = 0; i < `EVAL_SQUARES; i++)
            occupied[i] <= (board[i].raw != `EVAL_PIECE_WIDTH'(`EVAL_KIND_EMPTY)) &&
                           (board[i].fields.kind != piece_kind_t'(`EVAL_KIND_PAWN));
      if (occ_valid)
      begin
         if (occ_count > count_t'(`EVAL_PHASE_MAX))
            phase <= phase_t'(`EVAL_PHASE_MAX);     // Clamp
         else
            phase <= phase_t'(occ_count);
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         occ_valid  <= 1'b0;
         phase_done <= 1'b0;
      end
      else
      begin
         occ_valid <= term_start;
         if (term_start)
            phase_done <= 1'b0;
         else if (occ_valid)
            phase_done <= 1'b1;                     // Held until next term_start
      end
   end

   // Once done, phase holds steady and in range until the next run
   assert property (@(posedge clk) disable iff (reset)
                    phase_done && !term_start |=>
                       $stable(phase) && phase <= phase_t'(`EVAL_PHASE_MAX));

endmodule

`default_nettype wire

// ==== verilog/material_sum.sv ====
//**************************************************************************
// Material scanner, eight squares per cycle into mg and eg totals
//**************************************************************************
`include "eval_defs.svh"
`default_nettype none

module material_sum
   import eval_pkg::*;
(
   input  wire         clk,
   input  wire         reset,
   input  wire         term_start,
   input  wire board_t board,
   output sum_t        material_mg,
   output sum_t        material_eg,
   output logic        material_done
);

   logic [2:0] group;                               // Next lane group
   logic [2:0] grp;                                 // Group decoded this cycle
   logic       busy;
   square_u    sq;
   sum_t       lane_mg, lane_eg;                    // Signed sum of one group

   function automatic sum_t piece_value(input piece_kind_t kind, input logic eg);
      case (kind)
         piece_kind_t'(`EVAL_KIND_PAWN):   piece_value = eg ? sum_t'(`EVAL_PAWN_EG)
                                                            : sum_t'(`EVAL_PAWN_MG);
         piece_kind_t'(`EVAL_KIND_KNIGHT): piece_value = eg ? sum_t'(`EVAL_KNIGHT_EG)
                                                            : sum_t'(`EVAL_KNIGHT_MG);
         piece_kind_t'(`EVAL_KIND_BISHOP): piece_value = eg ? sum_t'(`EVAL_BISHOP_EG)
                                                            : sum_t'(`EVAL_BISHOP_MG);
         piece_kind_t'(`EVAL_KIND_ROOK):   piece_value = eg ? sum_t'(`EVAL_ROOK_EG)
                                                            : sum_t'(`EVAL_ROOK_MG);
         piece_kind_t'(`EVAL_KIND_QUEEN):  piece_value = eg ? sum_t'(`EVAL_QUEEN_EG)
                                                            : sum_t'(`EVAL_QUEEN_MG);
         default:                          piece_value = '0;   // King, empty
      endcase
   endfunction

   assign grp = term_start ? 3'd0 : group;          // Group 0 rides on the start

   always_comb
   begin
      lane_mg = '0;
      lane_eg = '0;
      sq      = '0;
      for (int l = 0; l < `EVAL_SCAN_LANES; l++)
      begin
         sq = board[{grp, 3'(l)}];
         if (sq.fields.black)                       // Black counts against white
         begin
            lane_mg = lane_mg - piece_value(sq.fields.kind, 1'b0);
            lane_eg = lane_eg - piece_value(sq.fields.kind, 1'b1);
         end
         else
         begin
            lane_mg = lane_mg + piece_value(sq.fields.kind, 1'b0);
            lane_eg = lane_eg + piece_value(sq.fields.kind, 1'b1);
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         group         <= '0;
         busy          <= 1'b0;
         material_done <= 1'b0;
      end
      else if (term_start)
      begin
         group         <= 3'd1;
         busy          <= 1'b1;
         material_done <= 1'b0;
      end
      else if (busy)
      begin
         group <= group + 3'd1;                     // Wraps to 0 after the last group
         if (group == 3'd7)
         begin
            busy          <= 1'b0;
            material_done <= 1'b1;                  // Held until next term_start
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (term_start)
      begin
         material_mg <= lane_mg;                    // Old total dropped, group 0 loaded
         material_eg <= lane_eg;
      end
      else if (busy)
      begin
         material_mg <= material_mg + lane_mg;
         material_eg <= material_eg + lane_eg;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/latency_timer.sv ====
//**************************************************************************
// Blend latency timer, counts the taper pipeline depth
//**************************************************************************
`include "eval_defs.svh"
`default_nettype none

module latency_timer
(
   input  wire  clk,
   input  wire  reset,
   input  wire  timer_start,
   output logic timer_done
);

   logic [2:0] count;                               // Zero when idle

   assign timer_done = (count == 3'd1);             // Final count

   always_ff @(posedge clk)
   begin
      if (reset)
         count <= '0;
      else if (timer_start)
         count <= 3'(`EVAL_TAPER_LATENCY);
      else if (count != '0)
         count <= count - 3'd1;
   end

   // Done only ever answers a start exactly one pipeline depth back
   assert property (@(posedge clk) disable iff (reset)
                    timer_done |-> $past(timer_start, `EVAL_TAPER_LATENCY));

endmodule

`default_nettype wire

// ==== verilog/eval_control.sv ====
//**************************************************************************
// Evaluation sequencer: board capture, term start, blend wait, result hold
//**************************************************************************
`default_nettype none

module eval_control
   import eval_pkg::*;
(
   input  wire         clk,
   input  wire         reset,
   input  wire         board_valid,
   input  wire         attack_done,
   input  wire board_t board_in,
   input  wire         material_done,
   input  wire         phase_done,
   input  wire         timer_done,
   input  wire         clear_eval,
   output board_t      board,
   output logic        term_start,
   output logic        timer_start,
   output logic        eval_valid
);

   localparam logic [2:0] S_IDLE        = 3'd0;
   localparam logic [2:0] S_WAIT_ATTACK = 3'd1;
   localparam logic [2:0] S_WAIT_TERMS  = 3'd2;
   localparam logic [2:0] S_WAIT_BLEND  = 3'd3;
   localparam logic [2:0] S_HOLD        = 3'd4;

   logic [2:0] state;
   logic       board_valid_r;                       // Previous board_valid for edge detect

   always_ff @(posedge clk)
   begin
      if (state == S_IDLE)
         board <= board_in;                         // Follows input until the edge
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= S_IDLE;
         board_valid_r <= 1'b0;
         term_start    <= 1'b0;
         timer_start   <= 1'b0;
         eval_valid    <= 1'b0;
      end
      else
      begin
         term_start    <= 1'b0;                     // Single-cycle pulses
         timer_start   <= 1'b0;
         board_valid_r <= 1'b1;                     // Edges masked outside idle
         case (state)
            S_IDLE:
            begin
               board_valid_r <= board_valid;
               if (board_valid && !board_valid_r)
                  state <= S_WAIT_ATTACK;
            end
            S_WAIT_ATTACK:
            begin
               if (attack_done)
               begin
                  term_start <= 1'b1;
                  state      <= S_WAIT_TERMS;
               end
            end
            S_WAIT_TERMS:
            begin
               // Done levels from the last board are still up during term_start
               if (!term_start && material_done && phase_done)
               begin
                  timer_start <= 1'b1;
                  state       <= S_WAIT_BLEND;
               end
            end
            S_WAIT_BLEND:
            begin
               if (timer_done)
               begin
                  eval_valid <= 1'b1;
                  state      <= S_HOLD;
               end
            end
            S_HOLD:
            begin
               if (clear_eval)
               begin
                  eval_valid <= 1'b0;
                  state      <= S_IDLE;
               end
            end
            default:
               state <= S_IDLE;
         endcase
      end
   end

   // A fresh term run never coincides with a held result
   assert property (@(posedge clk) disable iff (reset) term_start |=> !eval_valid);

endmodule

`default_nettype wire

// ==== verilog/eval_pkg.sv ====
//**************************************************************************
// Evaluator types: square word, board, material and blend widths
//**************************************************************************
`include "eval_defs.svh"
`default_nettype none

package eval_pkg;

   typedef logic [`EVAL_PIECE_WIDTH-2:0] piece_kind_t;

   // One square word, read whole or split into color and kind
   typedef union packed
   {
      logic [`EVAL_PIECE_WIDTH-1:0] raw;    // Whole code, zero is empty
      struct packed
      {
         logic        black;                // Set for black pieces
         piece_kind_t kind;
      } fields;
   } square_u;

   typedef square_u [`EVAL_SQUARES-1:0] board_t;     // Square 0 in the low nibble

   typedef logic signed [`EVAL_SUM_WIDTH-1:0]   sum_t;   // White positive
   typedef logic        [`EVAL_COUNT_WIDTH-1:0] count_t;
   typedef logic        [`EVAL_PHASE_WIDTH-1:0] phase_t; // 0 to 62
   typedef logic signed [`EVAL_CALC_WIDTH-1:0]  calc_t;
   typedef logic signed [`EVAL_SCORE_WIDTH-1:0] eval_t;

endpackage

`default_nettype wire

// ==== verilog/eval_defs.svh ====
//**************************************************************************
// Chess evaluator constants: widths, piece codes, material values
// and the blend pipeline constants
//**************************************************************************
`ifndef EVAL_DEFS_SVH
`define EVAL_DEFS_SVH

`define EVAL_SQUARES        64
`define EVAL_PIECE_WIDTH    4
`define EVAL_SCAN_LANES     8     // Squares summed per cycle
`define EVAL_SUM_WIDTH      24
`define EVAL_COUNT_WIDTH    7
`define EVAL_PHASE_WIDTH    6
`define EVAL_CALC_WIDTH     48    // Blend intermediates
`define EVAL_SCORE_WIDTH    20

`define EVAL_PHASE_MAX      62
`define EVAL_RECIP          16912 // 2^20 / 62, rounded down
`define EVAL_RECIP_SHIFT    20
`define EVAL_TAPER_LATENCY  4     // taper_blend stages

`define EVAL_KIND_EMPTY     0
`define EVAL_KIND_PAWN      1
`define EVAL_KIND_KNIGHT    2
`define EVAL_KIND_BISHOP    3
`define EVAL_KIND_ROOK      4
`define EVAL_KIND_QUEEN     5
`define EVAL_KIND_KING      6

// Middlegame / endgame pairs, king carries none
`define EVAL_PAWN_MG        82
`define EVAL_PAWN_EG        94
`define EVAL_KNIGHT_MG      337
`define EVAL_KNIGHT_EG      281
`define EVAL_BISHOP_MG      365
`define EVAL_BISHOP_EG      297
`define EVAL_ROOK_MG        477
`define EVAL_ROOK_EG        512
`define EVAL_QUEEN_MG       1025
`define EVAL_QUEEN_EG       936

`endif
